//--- bubble_display.f
logic/bubble_pkg.sv
logic/game_if.sv
logic/game_control.sv
logic/draw_sequencer.sv
logic/sprite_plotter.sv
logic/bubble_display.sv
testbench/tb_clock.sv
testbench/bubble_display_asserts.sv
testbench/bubble_display_tb.sv

//--- logic/bubble_display.sv
////////////////////////////////////////
// Top of the game display core
// Emits a plot stream for a 160x120 frame buffer
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module bubble_display (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                go,
    input  logic                                player_hit,
    input  logic                                moved,
    input  logic [bubble_pkg::x_bits-1:0]       player_x,
    input  logic [bubble_pkg::y_bits-1:0]       player_y,
    input  logic [bubble_pkg::x_bits-1:0]       bullet_x,
    input  logic [bubble_pkg::y_bits-1:0]       bullet_y,
    input  logic [bubble_pkg::x_bits-1:0]       enemy0_x,
    input  logic [bubble_pkg::y_bits-1:0]       enemy0_y,
    input  logic [bubble_pkg::x_bits-1:0]       enemy1_x,
    input  logic [bubble_pkg::y_bits-1:0]       enemy1_y,
    input  logic [bubble_pkg::x_bits-1:0]       enemy2_x,
    input  logic [bubble_pkg::y_bits-1:0]       enemy2_y,
    input  logic [bubble_pkg::colour_bits-1:0]  enemy_colour,
    output logic                                plot,
    output logic [bubble_pkg::x_bits-1:0]       pix_x,
    output logic [bubble_pkg::y_bits-1:0]       pix_y,
    output logic [bubble_pkg::colour_bits-1:0]  pix_colour,
    output logic                                play,
    output logic                                game_over,
    output logic                                redraw_done
);

    game_if game ();

    logic                   plot_start;
    logic                   plot_done;
    bubble_pkg::plot_mode_t plot_mode;

    game_control game_control_inst (
        .clk        (clk),
        .resetn     (resetn),
        .go         (go),
        .player_hit (player_hit),
        .game       (game)
    );

    draw_sequencer draw_sequencer_inst (
        .clk         (clk),
        .resetn      (resetn),
        .game        (game),
        .moved       (moved),
        .plot_done   (plot_done),
        .plot_start  (plot_start),
        .plot_mode   (plot_mode),
        .redraw_done (redraw_done)
    );

    sprite_plotter sprite_plotter_inst (
        .clk          (clk),
        .resetn       (resetn),
        .plot_start   (plot_start),
        .plot_mode    (plot_mode),
        .player_x     (player_x),
        .player_y     (player_y),
        .bullet_x     (bullet_x),
        .bullet_y     (bullet_y),
        .enemy0_x     (enemy0_x),
        .enemy0_y     (enemy0_y),
        .enemy1_x     (enemy1_x),
        .enemy1_y     (enemy1_y),
        .enemy2_x     (enemy2_x),
        .enemy2_y     (enemy2_y),
        .enemy_colour (enemy_colour),
        .plot         (plot),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .pix_colour   (pix_colour),
        .plot_done    (plot_done)
    );

    // Status for the outside world
    assign play      = game.play;
    assign game_over = game.game_over;

endmodule

`default_nettype wire

//--- logic/bubble_pkg.sv
////////////////////////////////////////
// Shared constants and state types for the arcade display core
// Screen geometry, sprite sizes, colours and the FSM enums
////////////////////////////////////////
`default_nettype none

package bubble_pkg;

    // Screen geometry
    localparam int screen_w = 160;
    localparam int screen_h = 120;
    localparam int x_bits   = 8;
    localparam int y_bits   = 7;

    localparam logic [2:0] player_width = 3'd3;  // Player square side
    localparam int enemy_count = 3;

    // Enemy square sides, index 0 is the first enemy drawn
    localparam logic [enemy_count-1:0][2:0] enemy_widths = {3'd7, 3'd5, 3'd3};

    localparam int colour_bits = 3;
    localparam logic [colour_bits-1:0] colour_black = 3'd0;
    localparam logic [colour_bits-1:0] colour_white = 3'd7;

    typedef enum logic [2:0] {
        level_select,
        load_level,
        level_pause,
        play_start,
        play,
        pausing,
        game_over
    } game_state_t;

    typedef enum logic {
        clear_screen,
        sprites
    } plot_mode_t;

    typedef enum logic [1:0] {
        idle,
        clearing,
        drawing
    } draw_state_t;

    // Sprite pass order
    typedef enum logic [1:0] {
        player,
        enemy,
        tip,
        bullet
    } plot_phase_t;

endpackage

`default_nettype wire

//--- logic/draw_sequencer.sv
////////////////////////////////////////
// Redraw scheduler
// Starts a clear pass then a sprite pass on a level load or a move
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module draw_sequencer (
    input  logic                    clk,
    input  logic                    resetn,
    game_if.seq                     game,
    input  logic                    moved,
    input  logic                    plot_done,
    output logic                    plot_start,
    output bubble_pkg::plot_mode_t  plot_mode,
    output logic                    redraw_done
);

    bubble_pkg::draw_state_t state;
    logic load_q;     // Previous load_level
    logic load_pend;  // Level load seen while busy
    logic load_rise;
    logic move_req;

    assign load_rise = game.load_level & ~load_q;

    // Moves only count in live play
    assign move_req = moved & game.play;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= bubble_pkg::idle;
            load_q      <= 1'b0;
            load_pend   <= 1'b0;
            plot_start  <= 1'b0;
            plot_mode   <= bubble_pkg::clear_screen;
            redraw_done <= 1'b0;
        end else begin
            load_q      <= game.load_level;
            plot_start  <= 1'b0;
            redraw_done <= 1'b0;

            // Keep a load that lands mid redraw so its clear still happens
            if (load_rise && state != bubble_pkg::idle) begin
                load_pend <= 1'b1;
            end

            case (state)
                bubble_pkg::idle: begin
                    if (load_rise || load_pend || move_req) begin
                        state      <= bubble_pkg::clearing;
                        plot_start <= 1'b1;
                        plot_mode  <= bubble_pkg::clear_screen;
                        load_pend  <= 1'b0;
                    end
                end
                bubble_pkg::clearing: begin
                    if (plot_done) begin
                        state      <= bubble_pkg::drawing;
                        plot_start <= 1'b1;
                        plot_mode  <= bubble_pkg::sprites;
                    end
                end
                bubble_pkg::drawing: begin
                    if (plot_done) begin
                        state       <= bubble_pkg::idle;
                        redraw_done <= 1'b1;
                    end
                end
                default: state <= bubble_pkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/game_control.sv
////////////////////////////////////////
// Game state FSM stepped by the go button
// Outputs are decoded from the registered state
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module game_control (
    input  logic   clk,
    input  logic   resetn,
    input  logic   go,
    input  logic   player_hit,
    game_if.ctrl   game
);

    bubble_pkg::game_state_t state;
    bubble_pkg::game_state_t state_next;

    // Press and release alternate between most states
    always_comb begin
        state_next = state;
        case (state)
            bubble_pkg::level_select: begin
                if (go) state_next = bubble_pkg::load_level;
            end
            bubble_pkg::load_level: begin
                if (!go) state_next = bubble_pkg::level_pause;
            end
            bubble_pkg::level_pause: begin
                if (go) state_next = bubble_pkg::play_start;
            end
            bubble_pkg::play_start: begin
                if (!go) state_next = bubble_pkg::play;
            end
            bubble_pkg::play: begin
                if (go) state_next = bubble_pkg::pausing;  // Pause wins over a hit
                else if (player_hit) state_next = bubble_pkg::game_over;
            end
            bubble_pkg::pausing: begin
                if (!go) state_next = bubble_pkg::level_pause;
            end
            bubble_pkg::game_over: begin
                if (go) state_next = bubble_pkg::load_level;
            end
            default: state_next = bubble_pkg::level_select;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= bubble_pkg::level_select;
        end else begin
            state <= state_next;
        end
    end

    assign game.load_level  = (state == bubble_pkg::load_level);
    assign game.level_pause = (state == bubble_pkg::level_pause);
    assign game.play        = (state == bubble_pkg::play);
    assign game.game_over   = (state == bubble_pkg::game_over);

endmodule

`default_nettype wire

//--- logic/game_if.sv
////////////////////////////////////////
// Decoded game state levels
// Driven by the game FSM, read by the draw sequencer
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface game_if;
    logic load_level;
    logic level_pause;
    logic play;
    logic game_over;

    modport ctrl (output load_level, output level_pause, output play, output game_over);
    modport seq (input load_level, input level_pause, input play, input game_over);
endinterface

`default_nettype wire

//--- logic/sprite_plotter.sv
////////////////////////////////////////
// Pixel engine, one plot per cycle
// Clear mode sweeps the screen, sprite mode draws the squares
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module sprite_plotter (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                plot_start,
    input  bubble_pkg::plot_mode_t              plot_mode,
    input  logic [bubble_pkg::x_bits-1:0]       player_x,
    input  logic [bubble_pkg::y_bits-1:0]       player_y,
    input  logic [bubble_pkg::x_bits-1:0]       bullet_x,
    input  logic [bubble_pkg::y_bits-1:0]       bullet_y,
    input  logic [bubble_pkg::x_bits-1:0]       enemy0_x,
    input  logic [bubble_pkg::y_bits-1:0]       enemy0_y,
    input  logic [bubble_pkg::x_bits-1:0]       enemy1_x,
    input  logic [bubble_pkg::y_bits-1:0]       enemy1_y,
    input  logic [bubble_pkg::x_bits-1:0]       enemy2_x,
    input  logic [bubble_pkg::y_bits-1:0]       enemy2_y,
    input  logic [bubble_pkg::colour_bits-1:0]  enemy_colour,
    output logic                                plot,
    output logic [bubble_pkg::x_bits-1:0]       pix_x,
    output logic [bubble_pkg::y_bits-1:0]       pix_y,
    output logic [bubble_pkg::colour_bits-1:0]  pix_colour,
    output logic                                plot_done
);

    bubble_pkg::plot_mode_t  mode;
    bubble_pkg::plot_phase_t phase;
    logic [1:0] enemy_idx;

    // Positions sampled at the start of a sprite pass
    logic [bubble_pkg::x_bits-1:0]      px_q, bx_q;
    logic [bubble_pkg::y_bits-1:0]      py_q, by_q;
    logic [bubble_pkg::x_bits-1:0]      ex_q [bubble_pkg::enemy_count];
    logic [bubble_pkg::y_bits-1:0]      ey_q [bubble_pkg::enemy_count];
    logic [bubble_pkg::colour_bits-1:0] ecol_q;

    logic [bubble_pkg::x_bits-1:0] ox;  // Corner of current square
    logic [2:0] dx, dy;                 // Offset inside the square
    logic [2:0] side;
    logic [1:0] next_idx;
    logic last_col, last_row;

    assign side = (phase == bubble_pkg::player) ? bubble_pkg::player_width
                                                : bubble_pkg::enemy_widths[enemy_idx];
    assign last_col = (dx == side - 3'd1);
    assign last_row = (dy == side - 3'd1);
    assign next_idx = (phase == bubble_pkg::player) ? 2'd0 : enemy_idx + 2'd1;

    always_ff @(posedge clk) begin
        plot_done <= 1'b0;
        if (!resetn) begin
            plot      <= 1'b0;
            plot_done <= 1'b0;
            mode      <= bubble_pkg::clear_screen;
            phase     <= bubble_pkg::player;
            enemy_idx <= 2'd0;
        end else if (!plot) begin
            if (plot_start) begin
                plot <= 1'b1;
                mode <= plot_mode;
                if (plot_mode == bubble_pkg::clear_screen) begin
                    pix_x      <= '0;
                    pix_y      <= '0;
                    pix_colour <= bubble_pkg::colour_black;
                end else begin
                    px_q   <= player_x;
                    py_q   <= player_y;
                    bx_q   <= bullet_x;
                    by_q   <= bullet_y;
                    ex_q[0] <= enemy0_x;
                    ey_q[0] <= enemy0_y;
                    ex_q[1] <= enemy1_x;
                    ey_q[1] <= enemy1_y;
                    ex_q[2] <= enemy2_x;
                    ey_q[2] <= enemy2_y;
                    ecol_q <= enemy_colour;
                    phase      <= bubble_pkg::player;
                    enemy_idx  <= 2'd0;
                    ox         <= player_x;
                    dx         <= 3'd0;
                    dy         <= 3'd0;
                    pix_x      <= player_x;
                    pix_y      <= player_y;
                    pix_colour <= bubble_pkg::colour_white;
                end
            end
        end else if (mode == bubble_pkg::clear_screen) begin
            // Raster sweep
            if (pix_x != bubble_pkg::screen_w - 1) begin
                pix_x <= pix_x + 1'b1;
            end else if (pix_y != bubble_pkg::screen_h - 1) begin
                pix_x <= '0;
                pix_y <= pix_y + 1'b1;
            end else begin
                plot      <= 1'b0;
                plot_done <= 1'b1;
            end
        end else begin
            case (phase)
                bubble_pkg::player, bubble_pkg::enemy: begin
                    if (!last_col) begin
                        pix_x <= pix_x + 1'b1;
                        dx    <= dx + 3'd1;
                    end else if (!last_row) begin
                        pix_x <= ox;
                        pix_y <= pix_y + 1'b1;
                        dx    <= 3'd0;
                        dy    <= dy + 3'd1;
                    end else if (phase == bubble_pkg::enemy
                                 && enemy_idx == bubble_pkg::enemy_count - 1) begin
                        phase      <= bubble_pkg::tip;
                        pix_x      <= px_q + 1'b1;
                        pix_y      <= py_q - 1'b1;
                        pix_colour <= bubble_pkg::colour_white;
                    end else begin
                        // Next enemy square from its corner
                        phase      <= bubble_pkg::enemy;
                        enemy_idx  <= next_idx;
                        ox         <= ex_q[next_idx];
                        dx         <= 3'd0;
                        dy         <= 3'd0;
                        pix_x      <= ex_q[next_idx];
                        pix_y      <= ey_q[next_idx];
                        pix_colour <= ecol_q;
                    end
                end
                bubble_pkg::tip: begin
                    phase <= bubble_pkg::bullet;
                    pix_x <= bx_q;
                    pix_y <= by_q;  // Colour stays white
                end
                default: begin
                    plot      <= 1'b0;
                    plot_done <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the display core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f bubble_display.f \
    --top-module bubble_display_tb -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1

//--- testbench/bubble_display_asserts.sv
////////////////////////////////////////
// Protocol checks on the display core outputs
// Bound into every bubble_display instance
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module bubble_display_asserts (
    input logic                               clk,
    input logic                               resetn,
    input logic                               plot,
    input logic [bubble_pkg::x_bits-1:0]      pix_x,
    input logic [bubble_pkg::y_bits-1:0]      pix_y,
    input logic                               play,
    input logic                               game_over,
    input logic                               redraw_done
);

    // Every plot lands inside the frame buffer
    assert property (@(posedge clk) disable iff (!resetn)
        plot |-> (pix_x < bubble_pkg::screen_w) && (pix_y < bubble_pkg::screen_h))
        else $error("plot outside the screen");

    assert property (@(posedge clk) disable iff (!resetn)
        !(play && game_over))
        else $error("play and game_over high together");

    assert property (@(posedge clk) disable iff (!resetn)
        redraw_done |=> !redraw_done)
        else $error("redraw_done longer than one cycle");

    assert property (@(posedge clk)
        !resetn |=> !plot)  // Plot engine quiet after reset
        else $error("plot high after reset");

endmodule

bind bubble_display bubble_display_asserts bubble_display_asserts_inst (.*);

`default_nettype wire

//--- testbench/bubble_display_golden.txt
# name go hit moved px py bx by e0x e0y e1x e1y e2x e2y colour plots play over
# moved: 0 none, 1 one strobe, 2 a second strobe during the redraw
reset_idle       0 0 0  76 110 77 90  10  5  60 20 120 40 4     0 0 0
load_press       1 0 0  76 110 77 90  10  5  60 20 120 40 4 19294 0 0
load_release     0 0 0  76 110 77 90  10  5  60 20 120 40 4     0 0 0
moved_in_pause   0 0 1  76 110 77 90  10  5  60 20 120 40 4     0 0 0
start_press      1 0 0  76 110 77 90  10  5  60 20 120 40 4     0 0 0
start_release    0 0 0  76 110 77 90  10  5  60 20 120 40 4     0 1 0
move_redraw      0 0 1  80 100 81 60  12  8  62 22 118 42 2 19294 1 0
move_lost        0 0 2  84 100 85 50  14 10  64 24 116 44 5 19294 1 0
pause_press      1 0 0  84 100 85 50  14 10  64 24 116 44 5     0 0 0
pause_release    0 0 0  84 100 85 50  14 10  64 24 116 44 5     0 0 0
resume_press     1 0 0  84 100 85 50  14 10  64 24 116 44 5     0 0 0
resume_release   0 0 0  84 100 85 50  14 10  64 24 116 44 5     0 1 0
player_hit       0 1 0  84 100 85 50  14 10  64 24 116 44 5     0 0 1
moved_in_over    0 0 1  84 100 85 50  14 10  64 24 116 44 5     0 0 1
restart_press    1 0 0  40 112 41 70   0  0 150  3 100 60 6 19294 0 0
restart_release  0 0 0  40 112 41 70   0  0 150  3 100 60 6     0 0 0

//--- testbench/bubble_display_tb.sv
////////////////////////////////////////
// Testbench for the display core
// Replays the golden file and checks every plot against a model
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module bubble_display_tb;

    localparam string golden_file = "testbench/bubble_display_golden.txt";
    localparam logic [31:0] seed = 32'h6328;
    localparam int timeout_margin = 200;  // Spare cycles per test
    localparam int max_tests = 32;
    localparam int field_count = 17;

    logic clk, resetn;
    logic go, player_hit, moved;
    logic [bubble_pkg::x_bits-1:0] player_x, bullet_x, enemy0_x, enemy1_x, enemy2_x;
    logic [bubble_pkg::y_bits-1:0] player_y, bullet_y, enemy0_y, enemy1_y, enemy2_y;
    logic [bubble_pkg::colour_bits-1:0] enemy_colour;
    logic plot, play, game_over, redraw_done;
    logic [bubble_pkg::x_bits-1:0] pix_x;
    logic [bubble_pkg::y_bits-1:0] pix_y;
    logic [bubble_pkg::colour_bits-1:0] pix_colour;

    // Fields: go hit moved px py bx by e0x e0y e1x e1y e2x e2y colour plots play over
    string names [max_tests];
    int vals [max_tests][field_count];
    string test_name = "setup";
    logic [17:0] exp_q [$];  // {x, y, colour}
    logic [31:0] rng_state = seed;
    int cycle_count = 0;
    int cycle_limit = 0;

    tb_clock tb_clock_inst (.clk(clk), .resetn(resetn));

    bubble_display bubble_display_inst (.*);

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            abort_run($sformatf("[FAIL] %s %s: expected %0d, actual %0d",
                                test_name, what, expected, actual));
        end
    endtask

    task automatic push_square(input int x0, input int y0, input int side, input int colour);
        for (int y = 0; y < side; y++) begin
            for (int x = 0; x < side; x++) begin
                exp_q.push_back({8'(x0 + x), 7'(y0 + y), 3'(colour)});
            end
        end
    endtask

    // Clear in raster order, then player, enemies, tip and bullet
    task automatic build_expected(input int t);
        exp_q.delete();
        if (vals[t][14] != 0) begin
            for (int y = 0; y < bubble_pkg::screen_h; y++) begin
                for (int x = 0; x < bubble_pkg::screen_w; x++) begin
                    exp_q.push_back({8'(x), 7'(y), bubble_pkg::colour_black});
                end
            end
            push_square(vals[t][3], vals[t][4], int'(bubble_pkg::player_width),
                        int'(bubble_pkg::colour_white));
            for (int e = 0; e < bubble_pkg::enemy_count; e++) begin
                push_square(vals[t][7 + 2 * e], vals[t][8 + 2 * e],
                            int'(bubble_pkg::enemy_widths[e]), vals[t][13]);
            end
            exp_q.push_back({8'(vals[t][3] + 1), 7'(vals[t][4] - 1), bubble_pkg::colour_white});
            exp_q.push_back({8'(vals[t][5]), 7'(vals[t][6]), bubble_pkg::colour_white});
        end
    endtask

    task automatic run_test(input int t);
        int plot_n;
        int redraws;
        int delay;
        bit done;
        test_name = names[t];
        build_expected(t);
        check_value("model length", vals[t][14], exp_q.size());
        plot_n  = 0;
        redraws = 0;
        done    = (vals[t][14] == 0);
        delay   = 3 + int'(next_random() % 32'd8);  // Idle cycles after the action
        @(negedge clk);
        go           = (vals[t][0] != 0);
        player_hit   = (vals[t][1] != 0);
        moved        = (vals[t][2] != 0);
        player_x     = 8'(vals[t][3]);
        player_y     = 7'(vals[t][4]);
        bullet_x     = 8'(vals[t][5]);
        bullet_y     = 7'(vals[t][6]);
        enemy0_x     = 8'(vals[t][7]);
        enemy0_y     = 7'(vals[t][8]);
        enemy1_x     = 8'(vals[t][9]);
        enemy1_y     = 7'(vals[t][10]);
        enemy2_x     = 8'(vals[t][11]);
        enemy2_y     = 7'(vals[t][12]);
        enemy_colour = 3'(vals[t][13]);
        while (!done || delay > 0) begin
            @(negedge clk);
            if (plot) begin
                if (plot_n >= exp_q.size()) begin
                    check_value("plot count", exp_q.size(), plot_n + 1);
                end
                check_value($sformatf("plot %0d x", plot_n),
                            int'(exp_q[plot_n][17:10]), int'(pix_x));
                check_value($sformatf("plot %0d y", plot_n),
                            int'(exp_q[plot_n][9:3]), int'(pix_y));
                check_value($sformatf("plot %0d colour", plot_n),
                            int'(exp_q[plot_n][2:0]), int'(pix_colour));
                plot_n++;
            end
            if (redraw_done) begin
                redraws++;
                done = 1'b1;
            end else if (done) begin
                delay--;
            end
            // Second strobe lands inside the clear pass
            moved = (vals[t][2] == 2 && plot_n == 500);
        end
        moved = 1'b0;
        check_value("plot count", vals[t][14], plot_n);
        check_value("redraw_done pulses", int'(vals[t][14] != 0), redraws);
        check_value("play", vals[t][15], int'(play));
        check_value("game_over", vals[t][16], int'(game_over));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, the DUT stopped responding",
                                cycle_count));
        end
    end

    initial begin
        int fd;
        int n_tests;
        int r;
        string line;
        go = 1'b0;
        player_hit = 1'b0;
        moved = 1'b0;
        {player_x, bullet_x, enemy0_x, enemy1_x, enemy2_x} = '0;
        {player_y, bullet_y, enemy0_y, enemy1_y, enemy2_y} = '0;
        enemy_colour = '0;
        n_tests = 0;
        fd = $fopen(golden_file, "r");
        if (fd == 0) abort_run("Cannot open the golden file");
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                if (n_tests >= max_tests) abort_run("Too many tests in the golden file");
                r = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                            names[n_tests], vals[n_tests][0], vals[n_tests][1],
                            vals[n_tests][2], vals[n_tests][3], vals[n_tests][4],
                            vals[n_tests][5], vals[n_tests][6], vals[n_tests][7],
                            vals[n_tests][8], vals[n_tests][9], vals[n_tests][10],
                            vals[n_tests][11], vals[n_tests][12], vals[n_tests][13],
                            vals[n_tests][14], vals[n_tests][15], vals[n_tests][16]);
                if (r != field_count + 1) abort_run($sformatf("Bad golden line: %s", line));
                n_tests++;
            end
        end
        $fclose(fd);
        if (n_tests == 0) abort_run("The golden file holds no tests");
        cycle_limit = n_tests * (bubble_pkg::screen_w * bubble_pkg::screen_h + 94
                                 + timeout_margin);
        wait (resetn === 1'b1);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
////////////////////////////////////////
// Testbench clock and reset source
// 4 ns clock, reset held low for 10 cycles
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // Half of the 4 ns period
    end

    // Release on a falling edge like the other stimulus
    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire
